//--- Makefile
VERILATOR ?= verilator
TOP ?= procTb
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(wildcard rtl/*.sv test/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): compile.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f compile.f

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
rtl/cpuPkg.sv
rtl/ctrlPkg.sv
rtl/alu.sv
rtl/memory.sv
rtl/regFile.sv
rtl/procControl.sv
rtl/nextPcLogic.sv
rtl/proc.sv
test/procTb.sv

//--- rtl/alu.sv
// Arithmetic and logic unit
`timescale 1ns/1ps

module alu (
	input cpuPkg::wordT a,
	input cpuPkg::wordT b,
	input ctrlPkg::aluOpT op,
	output cpuPkg::wordT result,
	output logic zero,
	output logic neg
);

	always_comb begin
		case (op)
			ctrlPkg::ALU_ADD: result = a + b;
			ctrlPkg::ALU_SUB: result = a - b;
			ctrlPkg::ALU_XOR: result = a ^ b;
			ctrlPkg::ALU_ANDN: result = a & ~b;
			default: result = a + b;
		endcase
	end

	// Flags look at the A operand so branches can test Rs directly
	assign zero = (a == '0);
	assign neg = a[cpuPkg::WORD_W-1];	// Sign bit

endmodule

//--- rtl/cpuPkg.sv
// Instruction set definitions
package cpuPkg;

	localparam int WORD_W = 16;
	localparam int REG_W = 3;
	localparam int OPC_W = 5;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] wordT;	// Data or byte address
	typedef logic [REG_W-1:0] regAddrT;
	typedef logic [OPC_W-1:0] opcodeT;

	// Opcodes
	localparam opcodeT OP_HALT = 5'b00000;
	localparam opcodeT OP_NOP = 5'b00001;
	localparam opcodeT OP_J = 5'b00100;
	localparam opcodeT OP_JR = 5'b00101;
	localparam opcodeT OP_JAL = 5'b00110;
	localparam opcodeT OP_ADDI = 5'b01000;
	localparam opcodeT OP_SUBI = 5'b01001;
	localparam opcodeT OP_XORI = 5'b01010;
	localparam opcodeT OP_ANDNI = 5'b01011;
	localparam opcodeT OP_BEQZ = 5'b01100;
	localparam opcodeT OP_BLTZ = 5'b01111;
	localparam opcodeT OP_ST = 5'b10000;
	localparam opcodeT OP_LD = 5'b10001;
	localparam opcodeT OP_LBI = 5'b11000;
	localparam opcodeT OP_RTYPE = 5'b11011;

	// R-type function codes in the low two bits
	localparam logic [1:0] FUNC_ADD = 2'b00;
	localparam logic [1:0] FUNC_SUB = 2'b01;
	localparam logic [1:0] FUNC_XOR = 2'b10;
	localparam logic [1:0] FUNC_ANDN = 2'b11;

	// Field positions
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 11;
	localparam int RS_HI = 10;
	localparam int RS_LO = 8;
	localparam int RT_HI = 7;
	localparam int RT_LO = 5;
	localparam int RD_HI = 4;	// R-type only
	localparam int RD_LO = 2;
	localparam int IMM5_HI = 4;
	localparam int IMM8_HI = 7;
	localparam int DISP_HI = 10;
	localparam int FUNC_HI = 1;

	localparam int MEM_DEPTH = 256;	// Words per memory
	localparam regAddrT LINK_REG = 3'd7;

endpackage

//--- rtl/ctrlPkg.sv
// Control path types
package ctrlPkg;

	typedef logic [1:0] aluOpT;
	localparam aluOpT ALU_ADD = 2'd0;
	localparam aluOpT ALU_SUB = 2'd1;	// a - b
	localparam aluOpT ALU_XOR = 2'd2;
	localparam aluOpT ALU_ANDN = 2'd3;	// a & ~b

	typedef logic [2:0] pcSelT;
	localparam pcSelT PC_SEQ = 3'd0;
	localparam pcSelT PC_BEQZ = 3'd1;
	localparam pcSelT PC_BLTZ = 3'd2;
	localparam pcSelT PC_JDISP = 3'd3;
	localparam pcSelT PC_JREG = 3'd4;

	// Which instruction field names the write register
	typedef logic [1:0] dstSelT;
	localparam dstSelT DST_RD = 2'd0;
	localparam dstSelT DST_RT = 2'd1;
	localparam dstSelT DST_RS = 2'd2;
	localparam dstSelT DST_LINK = 2'd3;

	typedef enum logic {
		RUN,
		HALTED
	} runStateT;

	typedef struct packed {
		aluOpT aluOp;
		logic bSrcImm;	// ALU B from imm5
		logic regWe;
		dstSelT dstSel;
		logic memWe;
		logic wbMem;
		logic wbPc;
		logic wbImm;
		pcSelT pcSel;
		logic halt;
		logic illegal;
	} ctrlT;

	typedef struct packed {
		cpuPkg::wordT imm5;	// Sign or zero extended per opcode
		cpuPkg::wordT imm8s;
		cpuPkg::wordT disp11s;
	} immT;

endpackage

//--- rtl/memory.sv
// Word-addressed memory
`timescale 1ns/1ps

module memory (
	input logic clk,
	input cpuPkg::wordT addr,
	output cpuPkg::wordT rdData,
	input cpuPkg::wordT wrData,
	input logic we
);

	localparam int IDX_W = $clog2(cpuPkg::MEM_DEPTH);

	cpuPkg::wordT mem [cpuPkg::MEM_DEPTH];
	logic [IDX_W-1:0] idx;

	assign idx = addr[IDX_W:1];	// Byte address to word index
	assign rdData = mem[idx];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wrData;
		end
	end

endmodule

//--- rtl/nextPcLogic.sv
// Program counter and run state
`timescale 1ns/1ps

module nextPcLogic (
	input logic clk,
	input logic rstN,
	input ctrlPkg::pcSelT pcSel,
	input logic halt,
	input logic illegal,
	input logic zero,
	input logic neg,
	input cpuPkg::wordT rsData,
	input ctrlPkg::immT imm,
	output cpuPkg::wordT pc,
	output cpuPkg::wordT pcPlus2,
	output logic running,
	output logic err
);

	ctrlPkg::runStateT state;
	cpuPkg::wordT branchTgt;
	cpuPkg::wordT jumpTgt;
	cpuPkg::wordT jrTgt;
	cpuPkg::wordT nextPc;

	assign pcPlus2 = pc + 16'd2;
	assign branchTgt = pcPlus2 + imm.imm8s;
	assign jumpTgt = pcPlus2 + imm.disp11s;
	assign jrTgt = rsData + imm.imm8s;	// Not pc relative
	assign running = (state == ctrlPkg::RUN);

	always_comb begin
		case (pcSel)
			ctrlPkg::PC_BEQZ: nextPc = zero ? branchTgt : pcPlus2;
			ctrlPkg::PC_BLTZ: nextPc = neg ? branchTgt : pcPlus2;
			ctrlPkg::PC_JDISP: nextPc = jumpTgt;
			ctrlPkg::PC_JREG: nextPc = jrTgt;
			default: nextPc = pcPlus2;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			state <= ctrlPkg::RUN;
			err <= 1'b0;
		end else if (state == ctrlPkg::RUN) begin
			if (halt || illegal) begin
				state <= ctrlPkg::HALTED;	// pc stays on the halting instruction
				err <= illegal;
			end else begin
				pc <= nextPc;
			end
		end
	end

endmodule

//--- rtl/proc.sv
// Single-cycle processor top
`timescale 1ns/1ps

module proc (
	input logic clk,
	input logic rstN,
	input logic progWe,
	input cpuPkg::wordT progAddr,
	input cpuPkg::wordT progData,
	output logic halted,
	output logic err,
	output cpuPkg::wordT pc,
	output logic commitValid,
	output logic regWe,
	output cpuPkg::regAddrT regWAddr,
	output cpuPkg::wordT regWData,
	output logic memWe,
	output cpuPkg::wordT memAddr,
	output cpuPkg::wordT memWData
);

	cpuPkg::wordT instr;
	cpuPkg::wordT instrAddr;
	ctrlPkg::ctrlT ctrl;
	ctrlPkg::immT imm;
	cpuPkg::wordT pcPlus2;
	cpuPkg::wordT rdDataA;	// Rs
	cpuPkg::wordT rdDataB;	// Rt
	cpuPkg::wordT aluB;
	cpuPkg::wordT aluResult;
	cpuPkg::wordT memRdData;
	logic zero;
	logic neg;
	logic running;
	logic execEn;

	// Nothing executes while held in reset or after halt
	assign execEn = running & rstN;
	assign halted = ~running;

	// Load port owns the instruction memory during reset
	assign instrAddr = rstN ? pc : progAddr;

	assign aluB = ctrl.bSrcImm ? imm.imm5 : rdDataB;

	always_comb begin
		case (ctrl.dstSel)
			ctrlPkg::DST_RD: regWAddr = instr[cpuPkg::RD_HI:cpuPkg::RD_LO];
			ctrlPkg::DST_RT: regWAddr = instr[cpuPkg::RT_HI:cpuPkg::RT_LO];
			ctrlPkg::DST_RS: regWAddr = instr[cpuPkg::RS_HI:cpuPkg::RS_LO];
			default: regWAddr = cpuPkg::LINK_REG;
		endcase
	end

	// Writeback priority is memory, then link, then lbi, then ALU
	assign regWData = ctrl.wbMem ? memRdData :
		ctrl.wbPc ? pcPlus2 :
		ctrl.wbImm ? imm.imm8s : aluResult;

	assign regWe = ctrl.regWe & execEn;
	assign memWe = ctrl.memWe & execEn;
	assign memAddr = aluResult;
	assign memWData = rdDataB;
	assign commitValid = execEn & ~ctrl.halt;	// Halt and illegal leave no trace

	procControl decoder (.instr(instr), .ctrl(ctrl), .imm(imm));

	nextPcLogic pcLogic (
		.clk(clk), .rstN(rstN), .pcSel(ctrl.pcSel), .halt(ctrl.halt),
		.illegal(ctrl.illegal), .zero(zero), .neg(neg), .rsData(rdDataA),
		.imm(imm), .pc(pc), .pcPlus2(pcPlus2), .running(running), .err(err)
	);

	regFile regs (
		.clk(clk), .rstN(rstN),
		.rdAddrA(instr[cpuPkg::RS_HI:cpuPkg::RS_LO]),
		.rdAddrB(instr[cpuPkg::RT_HI:cpuPkg::RT_LO]),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrAddr(regWAddr), .wrData(regWData), .we(regWe)
	);

	alu aluInst (.a(rdDataA), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(zero),
		.neg(neg));

	memory instrMem (.clk(clk), .addr(instrAddr), .rdData(instr), .wrData(progData),
		.we(progWe & ~rstN));

	memory dataMem (.clk(clk), .addr(aluResult), .rdData(memRdData), .wrData(rdDataB),
		.we(memWe));

endmodule

//--- rtl/procControl.sv
// Instruction decoder
`timescale 1ns/1ps

module procControl (
	input cpuPkg::wordT instr,
	output ctrlPkg::ctrlT ctrl,
	output ctrlPkg::immT imm
);

	cpuPkg::opcodeT opcode;
	logic [1:0] func;

	assign opcode = instr[cpuPkg::OPC_HI:cpuPkg::OPC_LO];
	assign func = instr[cpuPkg::FUNC_HI:0];

	// Extended immediates
	always_comb begin
		if (opcode == cpuPkg::OP_ANDNI)
			imm.imm5 = cpuPkg::wordT'(instr[cpuPkg::IMM5_HI:0]);	// Zero extend
		else
			imm.imm5 = cpuPkg::wordT'(signed'(instr[cpuPkg::IMM5_HI:0]));
		imm.imm8s = cpuPkg::wordT'(signed'(instr[cpuPkg::IMM8_HI:0]));
		imm.disp11s = cpuPkg::wordT'(signed'(instr[cpuPkg::DISP_HI:0]));
	end

	always_comb begin
		ctrl = '0;	// Add, Rd, sequential pc, no writes
		case (opcode)
			cpuPkg::OP_RTYPE: begin
				ctrl.regWe = 1'b1;
				ctrl.dstSel = ctrlPkg::DST_RD;
				case (func)
					cpuPkg::FUNC_ADD: ctrl.aluOp = ctrlPkg::ALU_ADD;
					cpuPkg::FUNC_SUB: ctrl.aluOp = ctrlPkg::ALU_SUB;
					cpuPkg::FUNC_XOR: ctrl.aluOp = ctrlPkg::ALU_XOR;
					cpuPkg::FUNC_ANDN: ctrl.aluOp = ctrlPkg::ALU_ANDN;
					default: ctrl.aluOp = ctrlPkg::ALU_ADD;
				endcase
			end
			cpuPkg::OP_ADDI, cpuPkg::OP_SUBI, cpuPkg::OP_XORI, cpuPkg::OP_ANDNI: begin
				ctrl.regWe = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.dstSel = ctrlPkg::DST_RT;
				ctrl.aluOp = ctrlPkg::aluOpT'(opcode[1:0]);	// Low opcode bits match ALU order
			end
			cpuPkg::OP_LBI: begin
				ctrl.regWe = 1'b1;
				ctrl.dstSel = ctrlPkg::DST_RS;
				ctrl.wbImm = 1'b1;
			end
			cpuPkg::OP_LD: begin
				ctrl.regWe = 1'b1;
				ctrl.bSrcImm = 1'b1;
				ctrl.dstSel = ctrlPkg::DST_RT;
				ctrl.wbMem = 1'b1;
			end
			cpuPkg::OP_ST: begin
				ctrl.memWe = 1'b1;
				ctrl.bSrcImm = 1'b1;	// Address is Rs + imm5
			end
			cpuPkg::OP_BEQZ: ctrl.pcSel = ctrlPkg::PC_BEQZ;
			cpuPkg::OP_BLTZ: ctrl.pcSel = ctrlPkg::PC_BLTZ;
			cpuPkg::OP_J: ctrl.pcSel = ctrlPkg::PC_JDISP;
			cpuPkg::OP_JAL: begin
				ctrl.pcSel = ctrlPkg::PC_JDISP;
				ctrl.regWe = 1'b1;
				ctrl.dstSel = ctrlPkg::DST_LINK;
				ctrl.wbPc = 1'b1;
			end
			cpuPkg::OP_JR: ctrl.pcSel = ctrlPkg::PC_JREG;
			cpuPkg::OP_HALT: ctrl.halt = 1'b1;
			cpuPkg::OP_NOP: ;
			default: begin
				ctrl.halt = 1'b1;
				ctrl.illegal = 1'b1;	// Unknown opcode
			end
		endcase
	end

endmodule

//--- rtl/regFile.sv
// General register file
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::regAddrT rdAddrA,
	input cpuPkg::regAddrT rdAddrB,
	output cpuPkg::wordT rdDataA,
	output cpuPkg::wordT rdDataB,
	input cpuPkg::regAddrT wrAddr,
	input cpuPkg::wordT wrData,
	input logic we
);

	cpuPkg::wordT regs [cpuPkg::NUM_REGS];

	// Combinational reads without bypass
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (we) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

//--- test/procTb.sv
// Processor testbench
`timescale 1ns/1ps

module procTb;

	localparam int HALT_TIMEOUT = 4 * cpuPkg::MEM_DEPTH;

	typedef struct packed {
		cpuPkg::wordT pc;
		logic regWe;
		cpuPkg::regAddrT regWAddr;
		cpuPkg::wordT regWData;
		logic memWe;
		cpuPkg::wordT memAddr;
		cpuPkg::wordT memWData;
	} commitT;

	logic clk = 1'b0;
	logic rstN;
	logic progWe;
	cpuPkg::wordT progAddr;
	cpuPkg::wordT progData;
	logic halted;
	logic err;
	cpuPkg::wordT pc;
	logic commitValid;
	logic regWe;
	cpuPkg::regAddrT regWAddr;
	cpuPkg::wordT regWData;
	logic memWe;
	cpuPkg::wordT memAddr;
	cpuPkg::wordT memWData;

	cpuPkg::wordT prog [cpuPkg::MEM_DEPTH];
	cpuPkg::wordT refMem [cpuPkg::MEM_DEPTH];	// Data memory is never reset
	commitT expQ [$];
	cpuPkg::wordT expPc;
	bit expErr;
	int progLen;
	integer seed;
	int errorCount = 0;
	int testErrors = 0;
	int checkCount = 0;
	int commitCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	proc proc_inst (
		.clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.halted(halted), .err(err), .pc(pc), .commitValid(commitValid), .regWe(regWe),
		.regWAddr(regWAddr), .regWData(regWData), .memWe(memWe), .memAddr(memAddr),
		.memWData(memWData)
	);

	always #4 clk = ~clk;

	function automatic void noteError();
		errorCount++;
		testErrors++;
	endfunction

	task automatic checkWord(input string name, input cpuPkg::wordT want, input cpuPkg::wordT got);
		checkCount++;
		assert (want === got) else begin
			$display("error at %0d ns: %s expected %h actual %h", $time, name, want, got);
			noteError();
		end
	endtask

	function automatic int pick(int n);
		return int'({$random(seed)} % n);
	endfunction

	// Instruction encoders
	function automatic cpuPkg::wordT encR(int rs, int rt, int rd, logic [1:0] func);
		return {cpuPkg::OP_RTYPE, 3'(rs), 3'(rt), 3'(rd), func};
	endfunction

	function automatic cpuPkg::wordT encI(cpuPkg::opcodeT op, int rs, int rt, int imm5);
		return {op, 3'(rs), 3'(rt), 5'(imm5)};
	endfunction

	function automatic cpuPkg::wordT encB(cpuPkg::opcodeT op, int rs, int imm8);
		return {op, 3'(rs), 8'(imm8)};	// lbi, branches and jr
	endfunction

	function automatic cpuPkg::wordT encJ(cpuPkg::opcodeT op, int disp);
		return {op, 11'(disp)};
	endfunction

	function automatic void emit(cpuPkg::wordT w);
		prog[progLen] = w;
		progLen++;
	endfunction

	// Unused words are halts tagged with their address
	function automatic void clearProgram();
		for (int i = 0; i < cpuPkg::MEM_DEPTH; i++)
			prog[i] = {cpuPkg::OP_HALT, 3'b101, 8'(i)};
		progLen = 0;
	endfunction

	// Executes prog on an ISA model and queues the expected commits
	function automatic void runReference();
		cpuPkg::wordT regs [8];
		cpuPkg::wordT curPc;
		cpuPkg::wordT ins;
		cpuPkg::wordT a;
		cpuPkg::wordT b;
		cpuPkg::wordT imm5s;
		cpuPkg::wordT imm8s;
		cpuPkg::wordT addr;
		cpuPkg::wordT nextPc;
		cpuPkg::opcodeT op;
		commitT c;
		bit done;
		int steps;
		expQ.delete();
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		curPc = '0;
		expErr = 1'b0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < cpuPkg::MEM_DEPTH) begin
			ins = prog[curPc[8:1]];
			op = ins[15:11];
			a = regs[ins[10:8]];	// Rs
			b = regs[ins[7:5]];	// Rt
			imm5s = {{11{ins[4]}}, ins[4:0]};
			imm8s = {{8{ins[7]}}, ins[7:0]};
			addr = a + imm5s;
			nextPc = curPc + 16'd2;
			c = '0;
			c.pc = curPc;
			case (op)
				cpuPkg::OP_RTYPE: begin
					c.regWe = 1'b1;
					c.regWAddr = ins[4:2];
					case (ins[1:0])
						cpuPkg::FUNC_ADD: c.regWData = a + b;
						cpuPkg::FUNC_SUB: c.regWData = a - b;
						cpuPkg::FUNC_XOR: c.regWData = a ^ b;
						default: c.regWData = a & ~b;
					endcase
				end
				cpuPkg::OP_ADDI, cpuPkg::OP_SUBI, cpuPkg::OP_XORI, cpuPkg::OP_ANDNI: begin
					c.regWe = 1'b1;
					c.regWAddr = ins[7:5];
					case (op)
						cpuPkg::OP_ADDI: c.regWData = a + imm5s;
						cpuPkg::OP_SUBI: c.regWData = a - imm5s;
						cpuPkg::OP_XORI: c.regWData = a ^ imm5s;
						default: c.regWData = a & ~{11'd0, ins[4:0]};	// Zero extended
					endcase
				end
				cpuPkg::OP_LBI: begin
					c.regWe = 1'b1;
					c.regWAddr = ins[10:8];
					c.regWData = imm8s;
				end
				cpuPkg::OP_LD: begin
					c.regWe = 1'b1;
					c.regWAddr = ins[7:5];
					c.regWData = refMem[addr[8:1]];
				end
				cpuPkg::OP_ST: begin
					c.memWe = 1'b1;
					c.memAddr = addr;
					c.memWData = b;
				end
				cpuPkg::OP_BEQZ: if (a == '0) nextPc = curPc + 16'd2 + imm8s;
				cpuPkg::OP_BLTZ: if (a[15]) nextPc = curPc + 16'd2 + imm8s;
				cpuPkg::OP_J: nextPc = curPc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
				cpuPkg::OP_JAL: begin
					c.regWe = 1'b1;
					c.regWAddr = cpuPkg::LINK_REG;
					c.regWData = curPc + 16'd2;
					nextPc = curPc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
				end
				cpuPkg::OP_JR: nextPc = a + imm8s;
				cpuPkg::OP_NOP: ;
				cpuPkg::OP_HALT: done = 1'b1;
				default: begin
					done = 1'b1;
					expErr = 1'b1;
				end
			endcase
			if (!done) begin
				expQ.push_back(c);
				if (c.regWe)
					regs[c.regWAddr] = c.regWData;
				if (c.memWe)
					refMem[c.memAddr[8:1]] = c.memWData;
				curPc = nextPc;
			end
			steps++;
		end
		expPc = curPc;	// Address of the halting instruction
	endfunction

	// Commit checker
	always @(posedge clk) begin
		commitT want;
		if (rstN && commitValid) begin
			commitCount++;
			if (expQ.size() == 0) begin
				$display("commit at pc %h arrived after the program should have halted", pc);
				noteError();
			end else begin
				want = expQ.pop_front();
				checkWord("pc", want.pc, pc);
				checkWord("regWe", 16'(want.regWe), 16'(regWe));
				checkWord("memWe", 16'(want.memWe), 16'(memWe));
				if (want.regWe) begin
					checkWord("regWAddr", 16'(want.regWAddr), 16'(regWAddr));
					checkWord("regWData", want.regWData, regWData);
				end
				if (want.memWe) begin
					checkWord("memAddr", want.memAddr, memAddr);
					checkWord("memWData", want.memWData, memWData);
				end
			end
		end
	end

	// Holds reset while the load port fills instruction memory
	task automatic loadProgram();
		rstN = 1'b0;
		for (int i = 0; i < cpuPkg::MEM_DEPTH; i++) begin
			@(posedge clk);
			#1;
			progWe = 1'b1;
			progAddr = cpuPkg::wordT'(i * 2);
			progData = prog[i];
		end
		@(posedge clk);
		#1;
		progWe = 1'b0;
		@(posedge clk);
		#1;
		rstN = 1'b1;
	endtask

	task automatic waitHalt(output bit ok);
		int cycles;
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		ok = halted;
	endtask

	task automatic runProgram(input string name);
		bit ok;
		runReference();
		testErrors = 0;
		commitCount = 0;
		loadProgram();
		assert (!halted && !err) else begin
			$display("reset left halted or err set at the start of %s", name);
			noteError();
		end
		waitHalt(ok);
		if (!ok) begin
			$display("processor did not halt within %0d cycles in %s", HALT_TIMEOUT, name);
			noteError();
		end else begin
			checkWord("pc", expPc, pc);
			checkWord("err", 16'(expErr), 16'(err));
			assert (expQ.size() == 0) else begin
				$display("%0d expected commits never appeared in %s", expQ.size(), name);
				noteError();
			end
			repeat (3) begin
				@(posedge clk);
				#1;
				assert (halted && !commitValid) else begin
					$display("processor kept running after halt in %s", name);
					noteError();
				end
				checkWord("pc", expPc, pc);	// Frozen
			end
		end
		testsRun++;
		if (testErrors == 0) begin
			$display("[%s] ok, %0d commits", name, commitCount);
		end else begin
			$display("[%s] %0d errors", name, testErrors);
			testsFailed++;
		end
	endtask

	// Preamble stores words 0 to 7 so later loads never read unwritten data
	task automatic buildRandom();
		int body;
		int haltIdx;
		int tgt;
		clearProgram();
		for (int w = 0; w < 8; w++) begin
			emit(encB(cpuPkg::OP_LBI, 1, pick(256)));
			emit(encI(cpuPkg::OP_ST, 0, 1, 2 * w));
		end
		body = 10 + pick(34);
		haltIdx = progLen + body;
		while (progLen < haltIdx) begin
			tgt = progLen + 1 + pick(haltIdx - progLen);	// Forward only
			case (pick(10))
				0, 1: emit(encR(pick(8), pick(8), 1 + pick(6), 2'(pick(4))));
				2, 3: emit(encI(cpuPkg::opcodeT'(cpuPkg::OP_ADDI + pick(4)), pick(8),
					1 + pick(6), pick(32)));
				4: emit(encB(cpuPkg::OP_LBI, 1 + pick(6), pick(256)));
				5: emit(encI(cpuPkg::OP_LD, 0, 1 + pick(6), 2 * pick(8)));
				6: emit(encI(cpuPkg::OP_ST, 0, pick(8), 2 * pick(8)));
				7: emit(encB(pick(2) ? cpuPkg::OP_BLTZ : cpuPkg::OP_BEQZ, pick(8),
					2 * (tgt - progLen - 1)));
				8: emit(encJ(pick(2) ? cpuPkg::OP_JAL : cpuPkg::OP_J, 2 * (tgt - progLen - 1)));
				default: emit(encJ(cpuPkg::OP_NOP, 0));
			endcase
		end
		emit(encJ(cpuPkg::OP_HALT, 0));
	endtask

	initial begin
		rstN = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		seed = 72;

		clearProgram();
		emit(encB(cpuPkg::OP_LBI, 1, 8'h35));
		emit(encB(cpuPkg::OP_LBI, 2, -6));
		emit(encI(cpuPkg::OP_ADDI, 1, 3, -3));
		emit(encI(cpuPkg::OP_SUBI, 1, 4, 7));
		emit(encI(cpuPkg::OP_XORI, 2, 5, -1));
		emit(encI(cpuPkg::OP_ANDNI, 2, 6, 5'h1f));	// Clears only the low five bits
		emit(encR(1, 2, 3, cpuPkg::FUNC_ADD));
		emit(encR(1, 2, 4, cpuPkg::FUNC_SUB));
		emit(encR(1, 2, 5, cpuPkg::FUNC_XOR));
		emit(encR(2, 1, 6, cpuPkg::FUNC_ANDN));
		emit(encJ(cpuPkg::OP_HALT, 0));
		runProgram("arith");

		clearProgram();
		emit(encB(cpuPkg::OP_LBI, 1, 8'h5a));
		emit(encB(cpuPkg::OP_LBI, 2, 8));
		emit(encI(cpuPkg::OP_ST, 2, 1, 4));
		emit(encI(cpuPkg::OP_LD, 2, 3, 4));
		emit(encB(cpuPkg::OP_LBI, 4, 8'h40));
		emit(encI(cpuPkg::OP_ST, 4, 2, -2));	// Negative offset
		emit(encI(cpuPkg::OP_LD, 4, 5, -2));
		emit(encJ(cpuPkg::OP_HALT, 0));
		runProgram("memory");

		clearProgram();
		emit(encB(cpuPkg::OP_LBI, 1, 0));
		emit(encB(cpuPkg::OP_BEQZ, 1, 2));	// Taken
		emit(encB(cpuPkg::OP_LBI, 2, 8'h11));
		emit(encB(cpuPkg::OP_BLTZ, 1, 2));	// Not taken
		emit(encB(cpuPkg::OP_LBI, 3, -1));
		emit(encB(cpuPkg::OP_BLTZ, 3, 2));	// Taken
		emit(encB(cpuPkg::OP_LBI, 2, 8'h22));
		emit(encB(cpuPkg::OP_BEQZ, 3, 2));	// Not taken
		emit(encJ(cpuPkg::OP_J, 4));
		emit(encB(cpuPkg::OP_LBI, 4, 1));
		emit(encB(cpuPkg::OP_LBI, 4, 2));
		emit(encJ(cpuPkg::OP_JAL, 2));
		emit(encB(cpuPkg::OP_LBI, 5, 3));
		emit(encB(cpuPkg::OP_LBI, 6, 8'h20));
		emit(encB(cpuPkg::OP_JR, 6, 4));	// To 0x24
		emit(encB(cpuPkg::OP_LBI, 5, 4));
		emit(encB(cpuPkg::OP_LBI, 5, 5));
		emit(encB(cpuPkg::OP_LBI, 5, 6));
		emit(encB(cpuPkg::OP_LBI, 5, 7));
		emit(encJ(cpuPkg::OP_HALT, 0));
		runProgram("control");

		clearProgram();
		emit(encB(cpuPkg::OP_LBI, 1, 1));
		emit({5'b11111, 11'd0});	// Undefined opcode
		emit(encB(cpuPkg::OP_LBI, 2, 2));
		runProgram("illegal");

		// Reset must clear err left by the previous program
		clearProgram();
		emit(encJ(cpuPkg::OP_NOP, 0));
		emit(encB(cpuPkg::OP_LBI, 1, 5));
		emit(encJ(cpuPkg::OP_HALT, 0));
		emit(encB(cpuPkg::OP_LBI, 2, 9));
		runProgram("halt");

		for (int t = 0; t < 10; t++) begin
			buildRandom();
			runProgram($sformatf("random%0d", t));
		end

		$display("%0d tests run, %0d failed, %0d checks, %0d errors", testsRun, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
